// ==== riscv_consts.svh ====
`ifndef RISCV_CONSTS_SVH
`define RISCV_CONSTS_SVH

// data and address width
`define RV_XLEN 32
`define RV_REG_COUNT 32
`define RV_RESET_PC 32'h0000_0000
// pc step without compressed instructions
`define RV_INSN_BYTES 4

// major opcodes in insn[6:0]
`define RV_OPC_LUI 7'b0110111
`define RV_OPC_AUIPC 7'b0010111
`define RV_OPC_JAL 7'b1101111
`define RV_OPC_JALR 7'b1100111
`define RV_OPC_BRANCH 7'b1100011
`define RV_OPC_LOAD 7'b0000011
`define RV_OPC_STORE 7'b0100011
`define RV_OPC_OP_IMM 7'b0010011
`define RV_OPC_OP 7'b0110011
`define RV_OPC_SYSTEM 7'b1110011

`endif

// ==== riscv_pkg.sv ====
`include "riscv_consts.svh"

package riscv_pkg;

  typedef logic [$clog2(`RV_REG_COUNT)-1:0] reg_addr_t;

  // immediate forms of arithmetic share the register-form values
  typedef enum logic [4:0] {
    OP_LUI, OP_AUIPC, OP_JAL, OP_JALR,
    OP_BEQ, OP_BNE, OP_BLT, OP_BGE, OP_BLTU, OP_BGEU,
    OP_LB, OP_LH, OP_LW, OP_LBU, OP_LHU,
    OP_ADD, OP_SUB, OP_SLL, OP_SLT, OP_SLTU,
    OP_XOR, OP_SRL, OP_SRA, OP_OR, OP_AND,
    OP_SB, OP_SH, OP_SW,
    OP_ECALL, OP_EBREAK, OP_ILLEGAL
  } op_e;

  typedef enum logic [1:0] {SIZE_BYTE, SIZE_HALF, SIZE_WORD} mem_size_e;

  typedef enum logic [1:0] {REQ_NONE, REQ_FETCH, REQ_LOAD, REQ_STORE} mem_kind_e;

  typedef enum logic [2:0] {
    ST_FETCH, ST_WAIT_INSN, ST_EXECUTE, ST_WAIT_DATA,
    ST_CHECK_PC, ST_WRITE_BACK, ST_TRAP
  } cpu_state_e;

  typedef struct packed {
    op_e                 op;
    reg_addr_t           rd;
    reg_addr_t           rs1;
    reg_addr_t           rs2;
    logic [`RV_XLEN-1:0] imm;
    logic                uses_imm;
  } decoded_t;

  typedef struct packed {
    logic [`RV_XLEN-1:0] result;
    logic [`RV_XLEN-1:0] next_pc;
  } alu_out_t;

  typedef struct packed {
    mem_kind_e           kind;
    logic [`RV_XLEN-1:0] addr;
    mem_size_e           size;
    logic                zero_ext;
    logic [`RV_XLEN-1:0] wdata;
  } mem_cmd_t;

endpackage

// ==== riscv_decoder.sv ====
`timescale 1ns/1ns
`include "riscv_consts.svh"

module riscv_decoder (
  input  logic [`RV_XLEN-1:0] insn,
  output riscv_pkg::decoded_t dec
);
  import riscv_pkg::*;

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  logic [`RV_XLEN-1:0] imm_i, imm_s, imm_b, imm_u, imm_j;

  assign opcode = insn[6:0];
  assign funct3 = insn[14:12];
  assign funct7 = insn[31:25];

  assign imm_i = {{20{insn[31]}}, insn[31:20]};
  assign imm_s = {{20{insn[31]}}, insn[31:25], insn[11:7]};
  assign imm_b = {{19{insn[31]}}, insn[31], insn[7], insn[30:25], insn[11:8], 1'b0};
  assign imm_u = {insn[31:12], 12'b0};
  assign imm_j = {{11{insn[31]}}, insn[31], insn[19:12], insn[20], insn[30:21], 1'b0};

  always_comb begin
    dec.op = OP_ILLEGAL;
    dec.rd = insn[11:7];
    dec.rs1 = insn[19:15];
    dec.rs2 = insn[24:20];
    dec.imm = imm_i;
    dec.uses_imm = 1'b0;
    case (opcode)
      `RV_OPC_LUI: begin
        dec.op = OP_LUI;
        dec.imm = imm_u;
      end
      `RV_OPC_AUIPC: begin
        dec.op = OP_AUIPC;
        dec.imm = imm_u;
      end
      `RV_OPC_JAL: begin
        dec.op = OP_JAL;
        dec.imm = imm_j;
      end
      `RV_OPC_JALR: begin
        if (funct3 == 3'b000) dec.op = OP_JALR;
        dec.uses_imm = 1'b1;
      end
      `RV_OPC_BRANCH: begin
        dec.imm = imm_b;
        case (funct3)
          3'b000: dec.op = OP_BEQ;
          3'b001: dec.op = OP_BNE;
          3'b100: dec.op = OP_BLT;
          3'b101: dec.op = OP_BGE;
          3'b110: dec.op = OP_BLTU;
          3'b111: dec.op = OP_BGEU;
          default: dec.op = OP_ILLEGAL;
        endcase
      end
      `RV_OPC_LOAD: begin
        dec.uses_imm = 1'b1;
        case (funct3)
          3'b000: dec.op = OP_LB;
          3'b001: dec.op = OP_LH;
          3'b010: dec.op = OP_LW;
          3'b100: dec.op = OP_LBU;
          3'b101: dec.op = OP_LHU;
          default: dec.op = OP_ILLEGAL;
        endcase
      end
      `RV_OPC_STORE: begin
        dec.imm = imm_s;
        dec.uses_imm = 1'b1;
        case (funct3)
          3'b000: dec.op = OP_SB;
          3'b001: dec.op = OP_SH;
          3'b010: dec.op = OP_SW;
          default: dec.op = OP_ILLEGAL;
        endcase
      end
      `RV_OPC_OP_IMM: begin
        dec.uses_imm = 1'b1;
        case (funct3)
          3'b000: dec.op = OP_ADD;
          3'b010: dec.op = OP_SLT;
          3'b011: dec.op = OP_SLTU;
          3'b100: dec.op = OP_XOR;
          3'b110: dec.op = OP_OR;
          3'b111: dec.op = OP_AND;
          3'b001: if (funct7 == 7'b0000000) dec.op = OP_SLL;
          default: begin
            // funct3 101 is srl or sra by funct7
            if (funct7 == 7'b0000000) dec.op = OP_SRL;
            else if (funct7 == 7'b0100000) dec.op = OP_SRA;
          end
        endcase
      end
      `RV_OPC_OP: begin
        case ({funct7, funct3})
          10'b0000000_000: dec.op = OP_ADD;
          10'b0100000_000: dec.op = OP_SUB;
          10'b0000000_001: dec.op = OP_SLL;
          10'b0000000_010: dec.op = OP_SLT;
          10'b0000000_011: dec.op = OP_SLTU;
          10'b0000000_100: dec.op = OP_XOR;
          10'b0000000_101: dec.op = OP_SRL;
          10'b0100000_101: dec.op = OP_SRA;
          10'b0000000_110: dec.op = OP_OR;
          10'b0000000_111: dec.op = OP_AND;
          default: dec.op = OP_ILLEGAL;
        endcase
      end
      `RV_OPC_SYSTEM: begin
        if (insn == 32'h0000_0073) dec.op = OP_ECALL;
        else if (insn == 32'h0010_0073) dec.op = OP_EBREAK;
      end
      default: dec.op = OP_ILLEGAL;
    endcase
  end

endmodule

// ==== riscv_regfile.sv ====
`timescale 1ns/1ns
`include "riscv_consts.svh"

module riscv_regfile (
  input  logic                clk,
  input  riscv_pkg::reg_addr_t rs1,
  input  riscv_pkg::reg_addr_t rs2,
  output logic [`RV_XLEN-1:0] rs1_data,
  output logic [`RV_XLEN-1:0] rs2_data,
  input  logic                we,
  input  riscv_pkg::reg_addr_t rd,
  input  logic [`RV_XLEN-1:0] rd_data
);

  // x0 has no storage
  logic [`RV_XLEN-1:0] regs [1:`RV_REG_COUNT-1];

  assign rs1_data = (rs1 == '0) ? '0 : regs[rs1];
  assign rs2_data = (rs2 == '0) ? '0 : regs[rs2];

  always_ff @(posedge clk) begin
    if (we && rd != '0) begin
      regs[rd] <= rd_data;
    end
  end

endmodule

// ==== riscv_alu.sv ====
`timescale 1ns/1ns
`include "riscv_consts.svh"

module riscv_alu (
  input  riscv_pkg::decoded_t dec,
  input  logic [`RV_XLEN-1:0] rs1_data,
  input  logic [`RV_XLEN-1:0] rs2_data,
  input  logic [`RV_XLEN-1:0] pc,
  output riscv_pkg::alu_out_t res
);
  import riscv_pkg::*;

  logic [`RV_XLEN-1:0] op_b, sum, pc_step, pc_rel;
  logic [4:0] shamt;
  logic taken;

  assign op_b = dec.uses_imm ? dec.imm : rs2_data;
  assign shamt = op_b[4:0];
  // also the effective address for loads, stores and jalr
  assign sum = rs1_data + op_b;
  assign pc_step = pc + `RV_XLEN'(`RV_INSN_BYTES);
  assign pc_rel = pc + dec.imm;

  always_comb begin
    case (dec.op)
      OP_BEQ: taken = rs1_data == rs2_data;
      OP_BNE: taken = rs1_data != rs2_data;
      OP_BLT: taken = $signed(rs1_data) < $signed(rs2_data);
      OP_BGE: taken = $signed(rs1_data) >= $signed(rs2_data);
      OP_BLTU: taken = rs1_data < rs2_data;
      OP_BGEU: taken = rs1_data >= rs2_data;
      default: taken = 1'b0;
    endcase
  end

  always_comb begin
    res.result = sum;
    res.next_pc = pc_step;
    case (dec.op)
      OP_LUI: res.result = dec.imm;
      OP_AUIPC: res.result = pc_rel;
      OP_JAL: begin
        res.result = pc_step;
        res.next_pc = pc_rel;
      end
      OP_JALR: begin
        res.result = pc_step;
        res.next_pc = {sum[`RV_XLEN-1:1], 1'b0};
      end
      OP_BEQ, OP_BNE, OP_BLT, OP_BGE, OP_BLTU, OP_BGEU: begin
        res.next_pc = taken ? pc_rel : pc_step;
      end
      OP_SUB: res.result = rs1_data - op_b;
      OP_SLL: res.result = rs1_data << shamt;
      OP_SLT: res.result = `RV_XLEN'($signed(rs1_data) < $signed(op_b));
      OP_SLTU: res.result = `RV_XLEN'(rs1_data < op_b);
      OP_XOR: res.result = rs1_data ^ op_b;
      OP_SRL: res.result = rs1_data >> shamt;
      OP_SRA: res.result = $signed(rs1_data) >>> shamt;
      OP_OR: res.result = rs1_data | op_b;
      OP_AND: res.result = rs1_data & op_b;
      default: res.result = sum;
    endcase
  end

endmodule

// ==== riscv_mem_port.sv ====
`timescale 1ns/1ns
`include "riscv_consts.svh"

module riscv_mem_port (
  input  logic                clk,
  input  logic                reset,
  input  riscv_pkg::mem_cmd_t cmd,
  output logic                done,
  output logic [`RV_XLEN-1:0] rdata,
  output logic                mem_valid,
  output logic                mem_instr,
  input  logic                mem_ready,
  output logic [`RV_XLEN-1:0] mem_addr,
  output logic [`RV_XLEN-1:0] mem_wdata,
  output logic [3:0]          mem_wstrb,
  input  logic [`RV_XLEN-1:0] mem_rdata
);
  import riscv_pkg::*;

  logic start;
  logic [`RV_XLEN-1:0] lane_word, load_value, store_data;
  logic [3:0] store_strb;

  // done blocks a second launch while control still holds the old command
  assign start = (cmd.kind != REQ_NONE) && !mem_valid && !done;
  assign lane_word = mem_rdata >> {cmd.addr[1:0], 3'b000};

  always_comb begin
    case (cmd.size)
      SIZE_BYTE: load_value = cmd.zero_ext ? {{(`RV_XLEN-8){1'b0}}, lane_word[7:0]} :
                                             {{(`RV_XLEN-8){lane_word[7]}}, lane_word[7:0]};
      SIZE_HALF: load_value = cmd.zero_ext ? {{(`RV_XLEN-16){1'b0}}, lane_word[15:0]} :
                                             {{(`RV_XLEN-16){lane_word[15]}}, lane_word[15:0]};
      default: load_value = mem_rdata;
    endcase
  end

  // data is replicated into every lane and the strobe picks one
  always_comb begin
    case (cmd.size)
      SIZE_BYTE: begin
        store_data = {4{cmd.wdata[7:0]}};
        store_strb = 4'b0001 << cmd.addr[1:0];
      end
      SIZE_HALF: begin
        store_data = {2{cmd.wdata[15:0]}};
        store_strb = cmd.addr[1] ? 4'b1100 : 4'b0011;
      end
      default: begin
        store_data = cmd.wdata;
        store_strb = 4'b1111;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      mem_valid <= 1'b0;
      done <= 1'b0;
    end else begin
      done <= mem_valid && mem_ready;
      if (mem_valid) begin
        if (mem_ready) mem_valid <= 1'b0;
      end else if (start) begin
        mem_valid <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (start) begin
      mem_addr <= {cmd.addr[`RV_XLEN-1:2], 2'b00};
      mem_instr <= cmd.kind == REQ_FETCH;
      mem_wdata <= store_data;
      mem_wstrb <= (cmd.kind == REQ_STORE) ? store_strb : 4'b0000;
    end
    if (mem_valid && mem_ready) begin
      rdata <= load_value;
    end
  end

endmodule

// ==== riscv_control.sv ====
`timescale 1ns/1ns
`include "riscv_consts.svh"

module riscv_control (
  input  logic                clk,
  input  logic                reset,
  output logic [`RV_XLEN-1:0] insn,
  input  riscv_pkg::decoded_t dec,
  input  riscv_pkg::alu_out_t res,
  input  logic [`RV_XLEN-1:0] rs2_data,
  output logic [`RV_XLEN-1:0] pc,
  output riscv_pkg::mem_cmd_t cmd,
  input  logic                done,
  input  logic [`RV_XLEN-1:0] rdata,
  output logic                we,
  output logic [`RV_XLEN-1:0] rd_data,
  output logic                trap
);
  import riscv_pkg::*;

  cpu_state_e state;
  mem_size_e size;
  logic is_load, is_store, is_jump, is_branch, is_fault;
  logic addr_misaligned, target_misaligned;

  assign is_load = dec.op inside {OP_LB, OP_LH, OP_LW, OP_LBU, OP_LHU};
  assign is_store = dec.op inside {OP_SB, OP_SH, OP_SW};
  assign is_jump = dec.op inside {OP_JAL, OP_JALR};
  assign is_branch = dec.op inside {OP_BEQ, OP_BNE, OP_BLT, OP_BGE, OP_BLTU, OP_BGEU};
  assign is_fault = dec.op inside {OP_ECALL, OP_EBREAK, OP_ILLEGAL};

  always_comb begin
    case (dec.op)
      OP_LB, OP_LBU, OP_SB: size = SIZE_BYTE;
      OP_LH, OP_LHU, OP_SH: size = SIZE_HALF;
      default: size = SIZE_WORD;
    endcase
  end

  assign addr_misaligned = (size == SIZE_WORD && res.result[1:0] != 2'b00) ||
                           (size == SIZE_HALF && res.result[0]);
  assign target_misaligned = res.next_pc[1:0] != 2'b00;

  // insn and regs do not change while waiting, so the command holds
  always_comb begin
    cmd.kind = REQ_NONE;
    cmd.addr = pc;
    cmd.size = SIZE_WORD;
    cmd.zero_ext = 1'b0;
    cmd.wdata = rs2_data;
    case (state)
      ST_FETCH, ST_WAIT_INSN: cmd.kind = REQ_FETCH;
      ST_WAIT_DATA: begin
        cmd.kind = is_store ? REQ_STORE : REQ_LOAD;
        cmd.addr = res.result;
        cmd.size = size;
        cmd.zero_ext = dec.op inside {OP_LBU, OP_LHU};
      end
      default: cmd.kind = REQ_NONE;
    endcase
  end

  // links come from the alu result, loads from the port
  assign we = (state == ST_WRITE_BACK) ||
              (state == ST_CHECK_PC && is_jump && !target_misaligned) ||
              (state == ST_WAIT_DATA && is_load && done);
  assign rd_data = is_load ? rdata : res.result;
  assign trap = state == ST_TRAP;

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= ST_FETCH;
      pc <= `RV_RESET_PC;
    end else begin
      case (state)
        ST_FETCH: state <= ST_WAIT_INSN;
        ST_WAIT_INSN: if (done) state <= ST_EXECUTE;
        ST_EXECUTE: begin
          if (is_fault) state <= ST_TRAP;
          else if (is_jump || is_branch) state <= ST_CHECK_PC;
          else if (is_load || is_store) state <= addr_misaligned ? ST_TRAP : ST_WAIT_DATA;
          else state <= ST_WRITE_BACK;
        end
        ST_WAIT_DATA: begin
          if (done) begin
            pc <= pc + `RV_XLEN'(`RV_INSN_BYTES);
            state <= ST_FETCH;
          end
        end
        ST_CHECK_PC: begin
          if (target_misaligned) begin
            state <= ST_TRAP;
          end else begin
            pc <= res.next_pc;
            state <= ST_FETCH;
          end
        end
        ST_WRITE_BACK: begin
          pc <= res.next_pc;
          state <= ST_FETCH;
        end
        ST_TRAP: state <= ST_TRAP;
        default: state <= ST_FETCH;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == ST_WAIT_INSN && done) begin
      insn <= rdata;
    end
  end

endmodule

// ==== riscv.sv ====
`timescale 1ns/1ns
`include "riscv_consts.svh"

module riscv (
  input  logic                clk,
  input  logic                reset,
  output logic                mem_valid,
  output logic                mem_instr,
  input  logic                mem_ready,
  output logic [`RV_XLEN-1:0] mem_addr,
  output logic [`RV_XLEN-1:0] mem_wdata,
  output logic [3:0]          mem_wstrb,
  input  logic [`RV_XLEN-1:0] mem_rdata,
  output logic                trap
);
  import riscv_pkg::*;

  logic [`RV_XLEN-1:0] insn, pc;
  logic [`RV_XLEN-1:0] rs1_data, rs2_data;
  logic [`RV_XLEN-1:0] rdata, rd_data;
  logic done, we;
  decoded_t dec;
  alu_out_t res;
  mem_cmd_t cmd;

  riscv_decoder decoder_inst (
    .insn (insn),
    .dec  (dec)
  );

  riscv_regfile regfile_inst (
    .clk      (clk),
    .rs1      (dec.rs1),
    .rs2      (dec.rs2),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data),
    .we       (we),
    .rd       (dec.rd),
    .rd_data  (rd_data)
  );

  riscv_alu alu_inst (
    .dec      (dec),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data),
    .pc       (pc),
    .res      (res)
  );

  riscv_mem_port mem_port_inst (
    .clk       (clk),
    .reset     (reset),
    .cmd       (cmd),
    .done      (done),
    .rdata     (rdata),
    .mem_valid (mem_valid),
    .mem_instr (mem_instr),
    .mem_ready (mem_ready),
    .mem_addr  (mem_addr),
    .mem_wdata (mem_wdata),
    .mem_wstrb (mem_wstrb),
    .mem_rdata (mem_rdata)
  );

  riscv_control control_inst (
    .clk      (clk),
    .reset    (reset),
    .insn     (insn),
    .dec      (dec),
    .res      (res),
    .rs2_data (rs2_data),
    .pc       (pc),
    .cmd      (cmd),
    .done     (done),
    .rdata    (rdata),
    .we       (we),
    .rd_data  (rd_data),
    .trap     (trap)
  );

endmodule

// ==== tb_riscv.sv ====
`timescale 1ns/1ns
`include "riscv_consts.svh"

module tb_riscv;

  logic clk;
  logic reset;
  logic mem_valid, mem_instr, mem_ready, trap;
  logic [31:0] mem_addr, mem_wdata, mem_rdata;
  logic [3:0] mem_wstrb;

  logic [31:0] mem [0:1023];
  logic [31:0] tests [0:1023];
  logic [31:0] exp_addr[$];
  logic [3:0] exp_strb[$];
  logic [31:0] exp_data[$];
  logic [31:0] last_fetch;
  logic [1:0] wait_cnt;
  logic hold_valid;
  logic accepted;
  logic [31:0] hold_addr, hold_wdata;
  logic [3:0] hold_wstrb;

  riscv riscv_inst (
    .clk       (clk),
    .reset     (reset),
    .mem_valid (mem_valid),
    .mem_instr (mem_instr),
    .mem_ready (mem_ready),
    .mem_addr  (mem_addr),
    .mem_wdata (mem_wdata),
    .mem_wstrb (mem_wstrb),
    .mem_rdata (mem_rdata),
    .trap      (trap)
  );

  always #2 clk = ~clk;

  task automatic flag_mismatch(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
    $display("Fail time=%0t signal=%s expected=%h actual=%h", $time, name, expected, actual);
    $display("TEST FAIL");
    $fatal(1);
  endtask

  task automatic abort_run(input string what);
    $display("Error at time %0t: %s", $time, what);
    $display("TEST FAIL");
    $fatal(1);
  endtask

  // word memory with random ready delay
  always @(posedge clk) begin
    if (reset) begin
      mem_ready <= 1'b0;
      wait_cnt <= 2'($urandom % 4);
    end else if (mem_valid && mem_ready) begin
      mem_ready <= 1'b0;
      wait_cnt <= 2'($urandom % 4);
      if (mem_instr) begin
        last_fetch = mem_addr;
      end
      if (mem_wstrb != 4'b0000) begin
        assert (exp_addr.size() > 0) else abort_run("store transfer not in the expected list");
        assert (mem_addr == exp_addr[0]) else flag_mismatch("mem_addr", exp_addr[0], mem_addr);
        assert (mem_wstrb == exp_strb[0])
          else flag_mismatch("mem_wstrb", 32'(exp_strb[0]), 32'(mem_wstrb));
        assert (mem_wdata == exp_data[0])
          else flag_mismatch("mem_wdata", exp_data[0], mem_wdata);
        void'(exp_addr.pop_front());
        void'(exp_strb.pop_front());
        void'(exp_data.pop_front());
        for (int b = 0; b < 4; b++) begin
          if (mem_wstrb[b]) mem[mem_addr[11:2]][8*b +: 8] = mem_wdata[8*b +: 8];
        end
      end
    end else if (mem_valid) begin
      if (wait_cnt == 0) begin
        mem_ready <= 1'b1;
        mem_rdata <= mem[mem_addr[11:2]];
      end else begin
        wait_cnt <= wait_cnt - 2'd1;
      end
    end
  end

  // bus rule checks
  always @(posedge clk) begin
    if (reset) begin
      hold_valid = 1'b0;
      accepted = 1'b0;
    end else begin
      if (hold_valid) begin
        assert (mem_valid) else abort_run("mem_valid dropped before the transfer was accepted");
        assert (mem_addr === hold_addr) else flag_mismatch("mem_addr", hold_addr, mem_addr);
        assert (mem_wdata === hold_wdata)
          else flag_mismatch("mem_wdata", hold_wdata, mem_wdata);
        assert (mem_wstrb === hold_wstrb)
          else flag_mismatch("mem_wstrb", 32'(hold_wstrb), 32'(mem_wstrb));
      end
      // valid drops in the cycle after an accepted transfer
      if (accepted) begin
        assert (!mem_valid) else flag_mismatch("mem_valid", 32'(0), 32'(mem_valid));
      end
      if (mem_valid) begin
        assert (mem_addr[1:0] == 2'b00)
          else flag_mismatch("mem_addr", 32'(0), 32'(mem_addr[1:0]));
        if (mem_instr) begin
          assert (mem_wstrb == 4'b0000) else flag_mismatch("mem_wstrb", 32'(0), 32'(mem_wstrb));
        end
      end
      if (trap) begin
        assert (!mem_valid) else flag_mismatch("mem_valid", 32'(0), 32'(mem_valid));
      end
      hold_valid = mem_valid && !mem_ready;
      accepted = mem_valid && mem_ready;
      hold_addr = mem_addr;
      hold_wdata = mem_wdata;
      hold_wstrb = mem_wstrb;
    end
  end

  initial begin
    int ptr;
    int n_img;
    int n_st;
    int cycles;
    int test_no;
    logic [31:0] trap_pc;

    clk = 1'b0;
    reset = 1'b1;
    mem_ready = 1'b0;
    mem_rdata = '0;
    last_fetch = '0;
    wait_cnt = '0;
    void'($urandom(32'h3ed2071b));
    $readmemh("riscv_tests.txt", tests);
    ptr = 0;
    test_no = 0;
    while (tests[ptr] !== 32'h0 && tests[ptr] !== 32'hx) begin
      n_img = tests[ptr];
      n_st = tests[ptr+1];
      trap_pc = tests[ptr+2];
      ptr = ptr + 3;
      // fill depends on the full byte address
      for (int i = 0; i < 1024; i++) begin
        mem[i] = 32'h5a5a_0000 ^ (i << 2);
      end
      for (int i = 0; i < n_img; i++) begin
        mem[i] = tests[ptr+i];
      end
      ptr = ptr + n_img;
      for (int i = 0; i < n_st; i++) begin
        exp_addr.push_back(tests[ptr]);
        exp_strb.push_back(tests[ptr+1][3:0]);
        exp_data.push_back(tests[ptr+2]);
        ptr = ptr + 3;
      end
      last_fetch = `RV_RESET_PC;

      @(posedge clk);
      reset <= 1'b1;
      repeat (8) @(posedge clk);
      reset <= 1'b0;

      cycles = 0;
      @(negedge clk);
      assert (!trap) else abort_run("trap is high right after reset");
      assert (!mem_valid) else abort_run("mem_valid is high right after reset");
      while (!trap && cycles < 4000) begin
        @(negedge clk);
        cycles++;
      end
      assert (trap) else abort_run($sformatf("test %0d timed out waiting for trap", test_no));
      assert (last_fetch == trap_pc) else flag_mismatch("last fetch address", trap_pc, last_fetch);
      // trap holds until the next reset
      repeat (12) begin
        @(negedge clk);
        assert (trap) else abort_run("trap dropped before reset");
      end
      assert (exp_addr.size() == 0)
        else abort_run($sformatf("test %0d missed %0d expected stores", test_no, exp_addr.size()));
      test_no++;
    end
    $display("TEST PASS");
    $finish;
  end

endmodule

// ==== riscv.f ====
+incdir+.
riscv_pkg.sv
riscv_decoder.sv
riscv_regfile.sv
riscv_alu.sv
riscv_mem_port.sv
riscv_control.sv
riscv.sv
tb_riscv.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP ?= tb_riscv
RTL_TOP ?= riscv
FLIST ?= riscv.f
BUILD ?= obj_dir
LOG ?= sim.log
RTL_SRCS ?= riscv_pkg.sv riscv_decoder.sv riscv_regfile.sv riscv_alu.sv \
            riscv_mem_port.sv riscv_control.sv riscv.sv

.PHONY: all run lint clean

all: run

$(BUILD)/V$(TOP): $(RTL_SRCS) tb_riscv.sv riscv_consts.svh $(FLIST)
	$(VERILATOR) --binary --timing -j 0 --top-module $(TOP) -f $(FLIST) -Mdir $(BUILD)

run: $(BUILD)/V$(TOP)
	-./$(BUILD)/V$(TOP) > $(LOG) 2>&1
	cat $(LOG)
	@if grep -q "TEST FAIL" $(LOG); then exit 1; fi
	@grep -q "TEST PASS" $(LOG)

lint:
	$(VERILATOR) --lint-only -Wall +incdir+. --top-module $(RTL_TOP) $(RTL_SRCS)

clean:
	rm -rf $(BUILD) $(LOG)

// ==== riscv_tests.txt ====
// per test: image word count, store count, trap pc; image words from address 0;
// then one line per expected store: address, strobe, data. a count of 0 ends the file
// arithmetic, shifts, compares, lui
00000019 0000000b 00000060
ff900093 00300113 002081b3 40208233 002092b3 4010d313 01c0d393 0020a433
0020b4b3 0f00c513 0023e5b3 03c0f613 123456b7
10302023 10402223 10502423 10602623 10702823 10802a23 10902c23 10a02e23
12b02023 12c02223 12d02423 00100073
00000100 f fffffffc
00000104 f fffffff6
00000108 f ffffffc8
0000010c f fffffffc
00000110 f 0000000f
00000114 f 00000001
00000118 f 00000000
0000011c f ffffff09
00000120 f 0000000f
00000124 f 00000038
00000128 f 12345000
// loads at each lane, stored back, then sb and sh lanes
00000015 0000000b 00000050
f08a80b7 f8108093 08102023
08000103 08304183 08100203 08201283 08005303 08002383 08204403
10202023 10302223 10402423 10502623 10602823 10702a23 10802c23
121000a3 12101323 121005a3 00100073
00000080 f f08a7f81
00000100 f ffffff81
00000104 f 000000f0
00000108 f 0000007f
0000010c f fffff08a
00000110 f 00007f81
00000114 f f08a7f81
00000118 f 0000008a
00000120 2 81818181
00000124 c 7f817f81
00000128 8 81818181
// branches and jumps, skipped stores must not appear
00000014 00000002 0000004c
00100093 fff00113 00208463 00209463 10102023 00114463 10102023 00116463
0020d463 10102023 0020f463 008001ef 10102023 04400267 10102023 10102023
10102023 10302023 10402223 00100073
00000100 f 00000030
00000104 f 00000038
// ecall
00000003 00000001 00000004
10002023 00000073 10002223
00000100 f 00000000
// illegal word
00000002 00000000 00000000
ffffffff 10002023
// misaligned lw
00000003 00000000 00000004
10200093 0000a103 10002023
// jalr to an address ending in 2
00000002 00000000 00000000
00a000e7 10002023
00000000
